/* hw/adc_frontend.sv */
////////////////////
// adc front end
// pin registers, neg-slope to signed, digital loop mux, drop count
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_defines.svh"

module adc_frontend (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  input  logic [`RP_ADC_PIN_W-1:0]  adc_dat_a_i,  // ch1 pins
  input  logic [`RP_ADC_PIN_W-1:0]  adc_dat_b_i,  // ch2 pins
  input  logic                      adc_valid_i,
  input  logic                      loop_en_i,    // take dac pair instead of pins
  input  sample_pkg::sample_pair_t  loop_pair_i,
  input  logic                      clr_drops_i,
  output logic [15:0]               drop_cnt_o,
  sample_if.src                     smp
);
  import sample_pkg::*;

  logic [`RP_ADC_PIN_W-1:0] pin_a_q;
  logic [`RP_ADC_PIN_W-1:0] pin_b_q;
  logic                     valid_q;
  sample_pair_t             adc_pair;
  logic                     drop;
  logic [15:0]              drop_cnt_q;

  // input registers, meant to sit in the io blocks
  always_ff @(posedge adc_clk)
  begin
    pin_a_q <= adc_dat_a_i;
    pin_b_q <= adc_dat_b_i;
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      valid_q <= 1'b0;
    else
      valid_q <= adc_valid_i;
  end

  assign adc_pair.a = nslope_flip(pin_a_q);  // to two's complement
  assign adc_pair.b = nslope_flip(pin_b_q);

  // one cycle after the pin edge, no stall possible
  assign smp.valid = valid_q;
  assign smp.pair  = loop_en_i ? loop_pair_i : adc_pair;

  ////////////////////
  // lost pairs
  ////////////////////
  assign drop = valid_q && !smp.ready;  // fifo full, pair is gone

  always_ff @(posedge adc_clk)
  begin
    if (reset_i || clr_drops_i)
      drop_cnt_q <= '0;
    else if (drop && (drop_cnt_q != '1))
      drop_cnt_q <= drop_cnt_q + 16'd1;  // saturates
  end

  assign drop_cnt_o = drop_cnt_q;

  // a counted drop means the fifo really refused
  a_no_drop_when_ready: assert property (@(posedge adc_clk) disable iff (reset_i)
    (smp.ready && !clr_drops_i) |=> (drop_cnt_o == $past(drop_cnt_o)));

endmodule

`default_nettype wire

/* hw/dac_serializer.sv */
////////////////////
// dac serializer
// pair to dac code, A then B on the shared 14-bit bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_defines.svh"

module dac_serializer (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  sample_if.snk                     smp,
  output logic [`RP_SAMPLE_W-1:0]   dac_dat_o,
  output logic                      dac_sel_o,    // 1 = channel A word
  output logic                      dac_wrt_o,    // word strobe
  output sample_pkg::sample_pair_t  last_pair_o   // signed, feeds digital loop
);
  import sample_pkg::*;

  // what the output registers show this cycle
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_A,
    ST_B
  } ser_state_t;

  ser_state_t   state_q;
  sample_pair_t pair_q;
  logic         accept;

  assign smp.ready = (state_q != ST_A);  // idle or last word going out
  assign accept    = smp.valid && smp.ready;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      state_q   <= ST_IDLE;
      pair_q    <= '0;
      dac_dat_o <= '0;
      dac_sel_o <= 1'b0;
      dac_wrt_o <= 1'b0;
    end
    else if (accept)
    begin
      pair_q    <= smp.pair;               // B waits here
      dac_dat_o <= nslope_flip(smp.pair.a);
      dac_sel_o <= 1'b1;
      dac_wrt_o <= 1'b1;
      state_q   <= ST_A;
    end
    else if (state_q == ST_A)
    begin
      dac_dat_o <= nslope_flip(pair_q.b);  // second word
      dac_sel_o <= 1'b0;
      dac_wrt_o <= 1'b1;
      state_q   <= ST_B;
    end
    else
    begin
      dac_sel_o <= 1'b0;  // data bus keeps last word
      dac_wrt_o <= 1'b0;
      state_q   <= ST_IDLE;
    end
  end

  assign last_pair_o = pair_q;

  // every A word is followed by its B word
  a_no_double_a: assert property (@(posedge adc_clk) disable iff (reset_i)
    (dac_wrt_o && dac_sel_o) |=> !(dac_wrt_o && dac_sel_o));

endmodule

`default_nettype wire

/* hw/rp_analog_top.sv */
////////////////////
// analog top level
// adc -> fifo -> dac path with bus housekeeping
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_defines.svh"

module rp_analog_top (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  // adc
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i,
  input  logic                     adc_valid_i,
  // dac, shared data bus
  output logic [`RP_SAMPLE_W-1:0]  dac_dat_o,
  output logic                     dac_sel_o,
  output logic                     dac_wrt_o,
  output logic [7:0]               led_o,
  // system bus
  input  logic [`RP_SYS_W-1:0]     sys_addr_i,
  input  logic [`RP_SYS_W-1:0]     sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [`RP_SYS_W-1:0]     sys_rdata_o,
  output logic                     sys_ack_o
);
  import sample_pkg::*;

  sample_if adc_smp ();  // frontend -> fifo
  sample_if dac_smp ();  // fifo -> serializer

  logic                      loop_en;
  logic                      clr_drops;
  logic [15:0]               drop_cnt;
  logic [`RP_FIFO_LVL_W-1:0] fifo_level;
  sample_pair_t              last_pair;  // loopback source

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_valid_i (adc_valid_i),
    .loop_en_i   (loop_en),
    .loop_pair_i (last_pair),
    .clr_drops_i (clr_drops),
    .drop_cnt_o  (drop_cnt),
    .smp         (adc_smp)
  );

  sample_fifo #(.DEPTH(`RP_FIFO_DEPTH)) i_fifo (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .wr      (adc_smp),
    .rd      (dac_smp),
    .level_o (fifo_level)
  );

  dac_serializer i_dac (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .smp         (dac_smp),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_wrt_o   (dac_wrt_o),
    .last_pair_o (last_pair)
  );

  sys_bus_regs i_regs (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .led_o        (led_o),
    .loop_en_o    (loop_en),
    .clr_drops_o  (clr_drops),
    .fifo_level_i (fifo_level),
    .drop_cnt_i   (drop_cnt)
  );

endmodule

`default_nettype wire

/* hw/sample_fifo.sv */
////////////////////
// sample pair fifo
// circular buffer with write on full when read
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_defines.svh"

module sample_fifo #(
  parameter int DEPTH = `RP_FIFO_DEPTH  // power of two
) (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  sample_if.snk                     wr,
  sample_if.src                     rd,
  output logic [`RP_FIFO_LVL_W-1:0] level_o
);
  import sample_pkg::*;

  localparam int                AW       = $clog2(DEPTH);
  localparam int                LVL_W    = `RP_FIFO_LVL_W;
  localparam logic [LVL_W-1:0]  FULL_LVL = LVL_W'(DEPTH);

  sample_pair_t     mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [LVL_W-1:0] count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full     = (count == FULL_LVL);
  assign wr.ready = !full || rd.ready;  // full but draining this edge is ok
  assign rd.valid = (count != '0);
  assign rd.pair  = mem[rd_ptr];        // head of queue
  assign do_wr    = wr.valid && wr.ready;
  assign do_rd    = rd.valid && rd.ready;
  assign level_o  = count;

  ////////////////////
  // storage
  ////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr.pair;
  end

  ////////////////////
  // pointers and fill
  ////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  a_level_bound: assert property (@(posedge adc_clk) disable iff (reset_i)
    count <= FULL_LVL);

  // head held while the serializer is busy, so a full write needs a read
  a_head_stable: assert property (@(posedge adc_clk) disable iff (reset_i)
    (rd.valid && !rd.ready) |=> $stable(rd.pair));

endmodule

`default_nettype wire

/* hw/sample_if.sv */
////////////////////
// sample pair stream
// valid/ready, transfer when both high on an edge
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface sample_if;
  import sample_pkg::*;

  logic         valid;  // pair on the wires is real
  logic         ready;  // sink can take it this edge
  sample_pair_t pair;   // held while valid && !ready

  // producer side
  modport src (
    output valid,
    output pair,
    input  ready
  );

  // consumer side
  modport snk (
    input  valid,
    input  pair,
    output ready
  );

endinterface

`default_nettype wire

/* hw/sample_pkg.sv */
////////////////////
// sample types
// signed sample, channel pair and the neg-slope code flip
////////////////////
`default_nettype none

`include "rp_defines.svh"

package sample_pkg;

  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t;  // two's complement

  typedef struct packed {
    sample_t a;  // channel A, upper half
    sample_t b;  // channel B
  } sample_pair_t;

  // converter code <-> two's complement
  // msb kept, rest inverted, so the same flip works both ways
  function automatic sample_t nslope_flip(input logic [`RP_SAMPLE_W-1:0] code);
    return {code[`RP_SAMPLE_W-1], ~code[`RP_SAMPLE_W-2:0]};
  endfunction

endpackage

`default_nettype wire

/* hw/sys_bus_pkg.sv */
////////////////////
// system bus types
// region codes and in-region register offset
////////////////////
`default_nettype none

`include "rp_defines.svh"

package sys_bus_pkg;

  // one region per 1 MB window, picked by addr[22:20]
  typedef enum logic [2:0] {
    REGION_HK  = `RP_REGION_HK,   // id, leds, digital loop
    REGION_SMP = `RP_REGION_SMP,  // fifo level, drop count
    REGION_2   = 3'd2,            // unused from here on
    REGION_3   = 3'd3,
    REGION_4   = 3'd4,
    REGION_5   = 3'd5,
    REGION_6   = 3'd6,
    REGION_7   = 3'd7
  } sys_region_t;

  // byte offset inside a region
  typedef logic [`RP_REGION_LSB-1:0] sys_offset_t;

endpackage

`default_nettype wire

/* hw/sys_bus_regs.sv */
////////////////////
// system bus registers
// 8-region decode, housekeeping and sample path status
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_defines.svh"

module sys_bus_regs (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  input  logic [`RP_SYS_W-1:0]      sys_addr_i,
  input  logic [`RP_SYS_W-1:0]      sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output logic [`RP_SYS_W-1:0]      sys_rdata_o,
  output logic                      sys_ack_o,
  output logic [7:0]                led_o,
  output logic                      loop_en_o,
  output logic                      clr_drops_o,   // one cycle pulse
  input  logic [`RP_FIFO_LVL_W-1:0] fifo_level_i,
  input  logic [15:0]               drop_cnt_i
);
  import sys_bus_pkg::*;

  sys_region_t          region;
  sys_offset_t          offset;
  logic [`RP_SYS_W-1:0] rd_mux;
  logic [`RP_SYS_W-1:0] rdata_q;
  logic                 ack_q;
  logic [7:0]           led_q;
  logic                 loop_q;
  logic                 clr_q;

  ////////////////////
  // address split
  ////////////////////
  assign region = sys_region_t'(sys_addr_i[`RP_REGION_LSB +: $bits(sys_region_t)]);
  assign offset = sys_addr_i[`RP_REGION_LSB-1:0];

  // read data, unused regions give zero
  always_comb
  begin
    rd_mux = '0;
    case (region)
      REGION_HK:
      begin
        case (offset)
          `RP_REG_ID:   rd_mux = `RP_ID_VALUE;
          `RP_REG_LED:  rd_mux = {24'h0, led_q};
          `RP_REG_LOOP: rd_mux = {31'h0, loop_q};
          default:      rd_mux = '0;
        endcase
      end
      REGION_SMP:
      begin
        case (offset)
          `RP_REG_FIFO_LVL: rd_mux = {{(`RP_SYS_W-`RP_FIFO_LVL_W){1'b0}}, fifo_level_i};
          `RP_REG_DROPS:    rd_mux = {16'h0, drop_cnt_i};
          default:          rd_mux = '0;
        endcase
      end
      default: rd_mux = '0;
    endcase
  end

  ////////////////////
  // writes and ack
  ////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      led_q   <= '0;
      loop_q  <= 1'b0;
      clr_q   <= 1'b0;
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q   <= sys_wen_i || sys_ren_i;      // every region answers
      rdata_q <= sys_ren_i ? rd_mux : '0;
      clr_q   <= sys_wen_i && (region == REGION_SMP) && (offset == `RP_REG_DROPS);
      if (sys_wen_i && (region == REGION_HK))
      begin
        if (offset == `RP_REG_LED)
          led_q <= sys_wdata_i[7:0];
        if (offset == `RP_REG_LOOP)
          loop_q <= sys_wdata_i[0];
        // id is read only
      end
    end
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign led_o       = led_q;
  assign loop_en_o   = loop_q;
  assign clr_drops_o = clr_q;

  a_one_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(sys_wen_i && sys_ren_i));

endmodule

`default_nettype wire

/* include/rp_defines.svh */
////////////////////
// analog path defines
// sample widths, fifo sizing, bus map and register offsets
////////////////////
`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

////////////////////
// sample path
////////////////////
`define RP_SAMPLE_W     14  // adc / dac sample width
`define RP_ADC_PIN_W    14  // adc pin bus, two low bits of 16-bit bus dropped
`define RP_FIFO_DEPTH   8   // sample pairs
`define RP_FIFO_LVL_W   4   // holds 0..depth

////////////////////
// system bus
////////////////////
`define RP_SYS_W        32
`define RP_REGION_LSB   20  // region field is addr[22:20]
`define RP_REGION_HK    3'd0
`define RP_REGION_SMP   3'd1

// region 0, housekeeping
`define RP_ID_VALUE     32'h5250_0014
`define RP_REG_ID       20'h00000
`define RP_REG_LED      20'h00004
`define RP_REG_LOOP     20'h00008

// region 1, sample path status
`define RP_REG_FIFO_LVL 20'h00000
`define RP_REG_DROPS    20'h00004

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run the analog path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_rp_analog \
  -f tb.f \
  -o Vtb_rp_analog

out="$(./obj_dir/Vtb_rp_analog)"
echo "$out"

if grep -q "^PASS: all tests$" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* sim/tb_rp_analog.sv */
////////////////////
// analog top testbench
// directed tests for the adc -> fifo -> dac path and bus registers
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rp_defines.svh"

module tb_rp_analog;

  localparam int TIMEOUT = 200;  // cycles per wait

  logic                     adc_clk;
  logic                     reset_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i;
  logic                     adc_valid_i;
  logic [`RP_SAMPLE_W-1:0]  dac_dat_o;
  logic                     dac_sel_o;
  logic                     dac_wrt_o;
  logic [7:0]               led_o;
  logic [`RP_SYS_W-1:0]     sys_addr_i;
  logic [`RP_SYS_W-1:0]     sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  logic [`RP_SYS_W-1:0]     sys_rdata_o;
  logic                     sys_ack_o;

  integer      seed = 77;
  int          errors;
  int          checks;
  int          test_start;
  logic [13:0] a_hold;     // A word waiting for its B
  logic [27:0] got_q[$];   // delivered {a, b} codes
  logic [27:0] sent_q[$];
  logic [13:0] code_a;
  logic [13:0] code_b;
  logic [31:0] rdata;
  int          idx;
  logic        found;

  rp_analog_top UUT (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_valid_i (adc_valid_i),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_wrt_o   (dac_wrt_o),
    .led_o       (led_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

  always #10 adc_clk = ~adc_clk;  // 20 ns period

  // dac bus monitor sampled mid-cycle
  always @(negedge adc_clk)
  begin
    if (!reset_i && dac_wrt_o)
    begin
      if (dac_sel_o)
        a_hold = dac_dat_o;
      else
        got_q.push_back({a_hold, dac_dat_o});  // pair complete
    end
  end

  ////////////////////
  // helpers
  ////////////////////
  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks = checks + 1;
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, msg, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    $display("FAIL: see errors above");
    $finish;
  endtask

  function automatic logic [31:0] make_addr(input logic [2:0] region, input logic [19:0] off);
    return {9'h0, region, off};  // region sits at addr[22:20]
  endfunction

  task automatic wait_ack();
    int n;
    n = 0;
    while (!sys_ack_o && n < TIMEOUT)
    begin
      @(negedge adc_clk);
      n = n + 1;
    end
    if (!sys_ack_o)
      timeout_fail("bus ack");
    else
      check(32'(n), 32'd0, "ack one cycle after strobe");
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    #1;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;  // single cycle strobe
    wait_ack();
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge adc_clk);
    #1;
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(posedge adc_clk);
    #1;
    sys_ren_i = 1'b0;
    wait_ack();
    data = sys_rdata_o;  // valid with ack
  endtask

  task automatic wait_wrt();
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!dac_wrt_o && n < TIMEOUT)
    begin
      @(negedge adc_clk);
      n = n + 1;
    end
    if (!dac_wrt_o)
      timeout_fail("DAC write strobe");
  endtask

  // dac bus quiet for 8 cycles in a row
  task automatic wait_idle();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 8 && n < TIMEOUT)
    begin
      @(negedge adc_clk);
      n = n + 1;
      quiet = dac_wrt_o ? 0 : quiet + 1;
    end
    if (quiet < 8)
      timeout_fail("DAC output idle");
  endtask

  task automatic send_pair(input logic [13:0] a, input logic [13:0] b);
    @(posedge adc_clk);
    #1;
    adc_dat_a_i = a;
    adc_dat_b_i = b;
    adc_valid_i = 1'b1;
    @(posedge adc_clk);
    #1;
    adc_valid_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("test %s: done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic reset_state_test();
    check(32'(dac_wrt_o), 32'd0, "dac_wrt_o after reset");
    check(32'(dac_sel_o), 32'd0, "dac_sel_o after reset");
    check(32'(dac_dat_o), 32'd0, "dac_dat_o after reset");
    check(32'(led_o), 32'd0, "led_o after reset");
    bus_read(make_addr(`RP_REGION_HK, `RP_REG_ID), rdata);
    check(rdata, `RP_ID_VALUE, "id register");
    bus_read(make_addr(`RP_REGION_SMP, `RP_REG_FIFO_LVL), rdata);
    check(rdata, 32'd0, "fifo level after reset");
    bus_read(make_addr(`RP_REGION_SMP, `RP_REG_DROPS), rdata);
    check(rdata, 32'd0, "drop count after reset");
    end_test("reset state");
  endtask

  task automatic pass_through_test();
    code_a = 14'($random(seed));
    code_b = 14'($random(seed));
    send_pair(code_a, code_b);
    wait_wrt();
    check(32'(dac_sel_o), 32'd1, "first word select");
    check(32'(dac_dat_o), 32'(code_a), "word A equals pin code");
    @(negedge adc_clk);
    check(32'(dac_wrt_o), 32'd1, "second word strobe");
    check(32'(dac_sel_o), 32'd0, "second word select");
    check(32'(dac_dat_o), 32'(code_b), "word B equals pin code");
    end_test("pass-through");
  endtask

  task automatic register_test();
    bus_write(make_addr(`RP_REGION_HK, `RP_REG_LED), 32'h0000_00a5);
    check(32'(led_o), 32'h0000_00a5, "led_o after write");
    bus_read(make_addr(`RP_REGION_HK, `RP_REG_LED), rdata);
    check(rdata, 32'h0000_00a5, "led read-back");
    bus_write(make_addr(`RP_REGION_HK, `RP_REG_LOOP), 32'd1);
    bus_read(make_addr(`RP_REGION_HK, `RP_REG_LOOP), rdata);
    check(rdata, 32'd1, "loop read-back");
    bus_write(make_addr(`RP_REGION_HK, `RP_REG_LOOP), 32'd0);  // loop off again
    bus_read(make_addr(3'd5, 20'h00004), rdata);
    check(rdata, 32'd0, "unused region reads zero");
    bus_write(make_addr(`RP_REGION_HK, `RP_REG_ID), 32'hdead_beef);
    bus_read(make_addr(`RP_REGION_HK, `RP_REG_ID), rdata);
    check(rdata, `RP_ID_VALUE, "id unchanged after write");
    end_test("registers");
  endtask

  task automatic back_pressure_test();
    sent_q.delete();
    got_q.delete();
    for (int i = 0; i < 24; i++)
    begin
      @(posedge adc_clk);
      #1;
      code_a = 14'($random(seed));
      code_b = {9'($random(seed)), 5'(i)};  // low bits make pairs distinct
      adc_dat_a_i = code_a;
      adc_dat_b_i = code_b;
      adc_valid_i = 1'b1;
      sent_q.push_back({code_a, code_b});
    end
    @(posedge adc_clk);
    #1;
    adc_valid_i = 1'b0;
    wait_idle();
    check(32'(got_q.size() < 24), 32'd1, "some pairs dropped");
    // delivered pairs keep the sent order
    idx = 0;
    foreach (got_q[k])
    begin
      found = 1'b0;
      while (idx < sent_q.size() && !found)
      begin
        found = (sent_q[idx] == got_q[k]);
        idx = idx + 1;
      end
      check(32'(found), 32'd1, "delivered pair in sent order");
    end
    bus_read(make_addr(`RP_REGION_SMP, `RP_REG_DROPS), rdata);
    check(rdata, 32'(24 - got_q.size()), "drop count");
    bus_write(make_addr(`RP_REGION_SMP, `RP_REG_DROPS), 32'd0);
    bus_read(make_addr(`RP_REGION_SMP, `RP_REG_DROPS), rdata);
    check(rdata, 32'd0, "drop count cleared");
    end_test("back-pressure");
  endtask

  task automatic digital_loop_test();
    logic [27:0] known;
    known = {14'h1234, 14'h0abc};
    send_pair(known[27:14], known[13:0]);
    wait_idle();
    got_q.delete();
    bus_write(make_addr(`RP_REGION_HK, `RP_REG_LOOP), 32'd1);
    for (int i = 0; i < 4; i++)
      send_pair(14'($random(seed)), 14'($random(seed)));  // pins ignored
    wait_idle();
    check(32'(got_q.size()), 32'd4, "pairs delivered in loop");
    foreach (got_q[k])
      check(32'(got_q[k]), 32'(known), "loop pair equals last sent");
    bus_write(make_addr(`RP_REGION_HK, `RP_REG_LOOP), 32'd0);
    got_q.delete();
    code_a = 14'($random(seed));
    code_b = 14'($random(seed));
    send_pair(code_a, code_b);
    wait_idle();
    check(32'(got_q.size()), 32'd1, "one pair after loop off");
    if (got_q.size() > 0)
      check(32'(got_q[0]), 32'({code_a, code_b}), "pins pass after loop off");
    end_test("digital loop");
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial
  begin
    adc_clk     = 1'b0;
    reset_i     = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    adc_valid_i = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    a_hold      = '0;
    errors      = 0;
    checks      = 0;
    test_start  = 0;
    repeat (5) @(posedge adc_clk);
    #1;
    reset_i = 1'b0;

    reset_state_test();
    pass_through_test();
    register_test();
    back_pressure_test();
    digital_loop_test();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hw/sys_bus_pkg.sv
hw/sample_pkg.sv
hw/sample_if.sv
hw/adc_frontend.sv
hw/sample_fifo.sv
hw/dac_serializer.sv
hw/sys_bus_regs.sv
hw/rp_analog_top.sv
sim/tb_rp_analog.sv
